/* tomasulo.f */
tomasulo_pkg.sv
tomasulo_ifs.sv
issue_unit.sv
execute_unit.sv
cdb_arbiter.sv
rob.sv
tomasulo.sv
tb_tomasulo.sv

/* tb_tomasulo.sv */
/*
  testbench for the tomasulo core
  directed tests checked against a register model in acceptance order
*/
module tb_tomasulo;
  timeunit 1ns;
  timeprecision 100ps;

  // instruction count across all tests, sizes the watchdog
  localparam int num_insts    = 28;
  localparam int limit_cycles = 200 * num_insts + 500;

  logic                   clk1;
  logic                   reset;
  logic [15:0]            inst;
  logic                   inst_valid;
  logic                   issue_ready;
  logic                   commit_valid;
  tomasulo_pkg::reg_idx_t commit_rd;
  tomasulo_pkg::data_t    commit_data;

  // reference register file and expected commit stream
  logic [7:0] model_reg [16];
  logic [3:0] exp_rd [$];
  logic [7:0] exp_data [$];
  logic [3:0] want_rd;
  logic [7:0] want_data;

  int     errors;
  int     commits;
  int     held_cycles;
  integer seed;

  tomasulo #(.ADD_RS_DEPTH(3), .MUL_RS_DEPTH(3), .MUL_LATENCY(3)) u_tomasulo (
    .clk1         (clk1),
    .reset        (reset),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .issue_ready  (issue_ready),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

  always #2 clk1 = ~clk1;

  function automatic logic [15:0] encode(logic [3:0] f, logic [3:0] s1, logic [3:0] s2,
                                         logic [3:0] d);
    return {f, s1, s2, d};
  endfunction

  // results follow the instruction rules, 8 bit wrap
  task automatic apply_model(input logic [15:0] word);
    logic [3:0] f;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] r;
    f = word[15:12];
    a = model_reg[word[11:8]];
    b = model_reg[word[7:4]];
    if (f == 4'b0000 || f == 4'b0001 || f == 4'b0010)
    begin
      if (f == 4'b0000)
        r = a + b;
      else if (f == 4'b0001)
        r = a - b;
      else
        r = a * b;
      model_reg[word[3:0]] = r;
      exp_rd.push_back(word[3:0]);
      exp_data.push_back(r);
    end
  endtask

  // called at a rising edge, returns at the edge that accepted the word
  task automatic send_inst(input logic [15:0] word);
    logic accepted;
    accepted = 1'b0;
    inst       <= word;
    inst_valid <= 1'b1;
    while (!accepted)
    begin
      @(negedge clk1);
      if (issue_ready)
        accepted = 1'b1;
      else
        held_cycles++;
      @(posedge clk1);
    end
    apply_model(word);
  endtask

  task automatic go_idle();
    inst_valid <= 1'b0;
    @(posedge clk1);
  endtask

  // bounded wait for outstanding commits, then a quiet tail
  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_rd.size() != 0 && n < 300)
    begin
      @(posedge clk1);
      n++;
    end
    repeat (10) @(posedge clk1);
  endtask

  // bounded wait for the next retirement, returns at a rising edge
  task automatic wait_commit();
    int n;
    n = 0;
    @(negedge clk1);
    while (!commit_valid && n < 300)
    begin
      @(negedge clk1);
      n++;
    end
    @(posedge clk1);
  endtask

  task automatic independent_ops();
    send_inst(encode(4'b0000, 4'd5, 4'd6, 4'd1));
    // 3 - 9 wraps
    send_inst(encode(4'b0001, 4'd3, 4'd9, 4'd2));
    go_idle();
    wait_drain();
  endtask

  task automatic dependent_chain();
    send_inst(encode(4'b0010, 4'd12, 4'd13, 4'd7));
    send_inst(encode(4'b0000, 4'd7, 4'd1, 4'd8));
    send_inst(encode(4'b0001, 4'd8, 4'd15, 4'd9));
    go_idle();
    wait_drain();
  endtask

  // add finishes ahead of the mul but retires after it
  task automatic commit_order();
    send_inst(encode(4'b0010, 4'd4, 4'd5, 4'd10));
    send_inst(encode(4'b0000, 4'd6, 4'd6, 4'd11));
    go_idle();
    wait_commit();
    // mul just retired, the finished add still waits in the reorder buffer
    send_inst(encode(4'b0001, 4'd11, 4'd10, 4'd12));
    go_idle();
    wait_drain();
  endtask

  task automatic rd_overwrite();
    send_inst(encode(4'b0010, 4'd1, 4'd2, 4'd3));
    send_inst(encode(4'b0000, 4'd4, 4'd5, 4'd3));
    // reader must see the younger write
    send_inst(encode(4'b0000, 4'd3, 4'd3, 4'd6));
    go_idle();
    wait_drain();
  endtask

  // each word reads the previous rd, so the stations back up
  task automatic random_burst();
    logic [3:0] f;
    logic [3:0] s2;
    logic [3:0] d;
    logic [3:0] prev;
    int         pick;
    held_cycles = 0;
    prev = 4'($random(seed));
    for (int i = 0; i < 12; i++)
    begin
      pick = {$random(seed)} % 3;
      f    = 4'(pick);
      s2   = 4'($random(seed));
      d    = 4'($random(seed));
      send_inst(encode(f, prev, s2, d));
      prev = d;
    end
    go_idle();
    assert (held_cycles > 0)
    else
    begin
      errors++;
      $display("Error: %0t issue_ready never dropped during the burst", $time);
    end
    wait_drain();
  endtask

  task automatic dropped_opcodes();
    send_inst(encode(4'b0000, 4'd1, 4'd2, 4'd4));
    // load and store style codes aimed at live registers
    send_inst(encode(4'b0100, 4'd4, 4'd4, 4'd4));
    send_inst(encode(4'b0001, 4'd4, 4'd3, 4'd5));
    send_inst(encode(4'b0110, 4'd5, 4'd5, 4'd5));
    send_inst(encode(4'b0010, 4'd5, 4'd4, 4'd6));
    go_idle();
    wait_drain();
  endtask

  // commit monitor, sampled mid cycle
  always @(negedge clk1)
  begin
    if (!reset && commit_valid)
    begin
      if (exp_rd.size() == 0)
      begin
        errors++;
        $display("Error: %0t commit seen with no instruction outstanding", $time);
      end
      else
      begin
        want_rd   = exp_rd.pop_front();
        want_data = exp_data.pop_front();
        commits++;
        assert (commit_rd == want_rd)
        else
        begin
          errors++;
          $display("Error: %0t commit_rd expected %0d got %0d", $time, want_rd, commit_rd);
        end
        assert (commit_data == want_data)
        else
        begin
          errors++;
          $display("Error: %0t commit_data expected %0d got %0d", $time, want_data,
                   commit_data);
        end
      end
    end
  end

  // watchdog
  initial
  begin
    repeat (limit_cycles) @(posedge clk1);
    $display("run stopped after %0d cycles with work still pending", limit_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    clk1        = 1'b0;
    reset       = 1'b1;
    inst        = '0;
    inst_valid  = 1'b0;
    errors      = 0;
    commits     = 0;
    held_cycles = 0;
    seed        = 32'hde48;
    for (int i = 0; i < 16; i++)
      model_reg[i] = 8'(i);
    repeat (10) @(posedge clk1);
    reset <= 1'b0;
    @(posedge clk1);
    independent_ops();
    dependent_chain();
    commit_order();
    rd_overwrite();
    random_burst();
    dropped_opcodes();
    if (exp_rd.size() != 0)
    begin
      errors++;
      $display("%0d expected commits never arrived", exp_rd.size());
    end
    $display("checked %0d commits, %0d errors", commits, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* tomasulo.sv */
/*
  tomasulo core top
  issue, add and mul units, bus arbiter and reorder buffer
*/
module tomasulo #(
  parameter int ADD_RS_DEPTH = 3,
  parameter int MUL_RS_DEPTH = 3,
  parameter int MUL_LATENCY  = 3
) (
  input  logic                   clk1,
  input  logic                   reset,
  input  logic [15:0]            inst,
  input  logic                   inst_valid,
  output logic                   issue_ready,
  output logic                   commit_valid,
  output tomasulo_pkg::reg_idx_t commit_rd,
  output tomasulo_pkg::data_t    commit_data
);

  // common data bus
  logic                cdb_valid;
  tomasulo_pkg::tag_t  cdb_tag;
  tomasulo_pkg::data_t cdb_data;

  dispatch_if add_disp ();
  dispatch_if mul_disp ();
  result_if   add_res ();
  result_if   mul_res ();
  rob_if      rob_bus ();
  commit_if   commit_bus ();

  issue_unit u_issue_unit (
    .clk1        (clk1),
    .reset       (reset),
    .inst        (inst),
    .inst_valid  (inst_valid),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_data    (cdb_data),
    .issue_ready (issue_ready),
    .add_disp    (add_disp.source),
    .mul_disp    (mul_disp.source),
    .rob_port    (rob_bus.issue),
    .commit_in   (commit_bus.sink)
  );

  // single cycle add/sub
  execute_unit #(.RS_DEPTH(ADD_RS_DEPTH), .LATENCY(1)) u_add_unit (
    .clk1      (clk1),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_data  (cdb_data),
    .disp      (add_disp.sink),
    .res       (add_res.unit)
  );

  execute_unit #(.RS_DEPTH(MUL_RS_DEPTH), .LATENCY(MUL_LATENCY)) u_mul_unit (
    .clk1      (clk1),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_data  (cdb_data),
    .disp      (mul_disp.sink),
    .res       (mul_res.unit)
  );

  cdb_arbiter u_cdb_arbiter (
    .clk1      (clk1),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_data  (cdb_data),
    .add_res   (add_res.arbiter),
    .mul_res   (mul_res.arbiter)
  );

  rob u_rob (
    .clk1       (clk1),
    .reset      (reset),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_data   (cdb_data),
    .rob_port   (rob_bus.rob),
    .commit_out (commit_bus.source)
  );

  // retirement is visible at the pins
  assign commit_valid = commit_bus.valid;
  assign commit_rd    = commit_bus.rd;
  assign commit_data  = commit_bus.data;

endmodule

/* rob.sv */
/*
  reorder buffer
  circular buffer of results, retired in program order
*/
module rob (
  input  logic                clk1,
  input  logic                reset,
  input  logic                cdb_valid,
  input  tomasulo_pkg::tag_t  cdb_tag,
  input  tomasulo_pkg::data_t cdb_data,
  rob_if.rob                  rob_port,
  commit_if.source            commit_out
);

  localparam int CNT_W = $clog2(tomasulo_pkg::rob_depth) + 1;

  tomasulo_pkg::reg_idx_t ent_rd  [tomasulo_pkg::rob_depth];
  tomasulo_pkg::data_t    ent_val [tomasulo_pkg::rob_depth];
  logic [tomasulo_pkg::rob_depth-1:0] ent_done;

  tomasulo_pkg::tag_t head;
  tomasulo_pkg::tag_t tail;
  logic [CNT_W-1:0]   count;
  logic               do_commit;

  assign rob_port.tail_tag = tail;
  assign rob_port.full     = (count == CNT_W'(tomasulo_pkg::rob_depth));

  // operand lookups, caller only asks for live entries
  assign rob_port.j_ready = ent_done[rob_port.qj_tag];
  assign rob_port.j_data  = ent_val[rob_port.qj_tag];
  assign rob_port.k_ready = ent_done[rob_port.qk_tag];
  assign rob_port.k_data  = ent_val[rob_port.qk_tag];

  // head retires once its value is in
  assign do_commit       = (count != '0) && ent_done[head];
  assign commit_out.valid = do_commit;
  assign commit_out.tag   = head;
  assign commit_out.rd    = ent_rd[head];
  assign commit_out.data  = ent_val[head];

  always_ff @(posedge clk1)
  begin
    if (reset)
    begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      ent_done <= '0;
    end
    else
    begin
      // bus tag always names a live entry, never the tail slot
      if (cdb_valid)
      begin
        ent_done[cdb_tag] <= 1'b1;
        ent_val[cdb_tag]  <= cdb_data;
      end
      if (do_commit)
      begin
        ent_done[head] <= 1'b0;
        head           <= head + 1'b1;
      end
      if (rob_port.alloc)
      begin
        ent_rd[tail]   <= rob_port.alloc_rd;
        ent_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      // occupancy tracks alloc minus retire
      case ({rob_port.alloc, do_commit})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* cdb_arbiter.sv */
/*
  common data bus arbiter
  one result per cycle, alternating priority on conflict
*/
module cdb_arbiter (
  input  logic                clk1,
  input  logic                reset,
  output logic                cdb_valid,
  output tomasulo_pkg::tag_t  cdb_tag,
  output tomasulo_pkg::data_t cdb_data,
  result_if.arbiter           add_res,
  result_if.arbiter           mul_res
);

  logic prio_mul;
  logic both;
  logic grant_mul;

  assign both      = add_res.valid && mul_res.valid;
  // mul wins when alone or when it holds priority
  assign grant_mul = mul_res.valid && (!add_res.valid || prio_mul);

  assign cdb_valid = add_res.valid || mul_res.valid;
  assign cdb_tag   = grant_mul ? mul_res.tag : add_res.tag;
  assign cdb_data  = grant_mul ? mul_res.data : add_res.data;

  // loser holds its result and retries
  assign add_res.stall = both && grant_mul;
  assign mul_res.stall = both && !grant_mul;

  always_ff @(posedge clk1)
  begin
    if (reset)
      prio_mul <= 1'b0;
    else if (both)
      prio_mul <= !prio_mul;
  end

endmodule

/* execute_unit.sv */
/*
  execute unit
  reservation station snooping the data bus, feeding a pipelined ALU
*/
module execute_unit #(
  parameter int RS_DEPTH = 3,
  parameter int LATENCY  = 1
) (
  input  logic                clk1,
  input  logic                reset,
  input  logic                cdb_valid,
  input  tomasulo_pkg::tag_t  cdb_tag,
  input  tomasulo_pkg::data_t cdb_data,
  dispatch_if.sink            disp,
  result_if.unit              res
);

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  // station entries
  logic [RS_DEPTH-1:0] rs_busy;
  logic [RS_DEPTH-1:0] rs_wait_j;
  logic [RS_DEPTH-1:0] rs_wait_k;
  tomasulo_pkg::func_t rs_func [RS_DEPTH];
  tomasulo_pkg::tag_t  rs_tag  [RS_DEPTH];
  tomasulo_pkg::data_t rs_vj   [RS_DEPTH];
  tomasulo_pkg::tag_t  rs_qj   [RS_DEPTH];
  tomasulo_pkg::data_t rs_vk   [RS_DEPTH];
  tomasulo_pkg::tag_t  rs_qk   [RS_DEPTH];

  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    sel_idx;
  logic                sel_found;
  logic                advance;
  tomasulo_pkg::data_t alu_out;

  // result pipeline
  logic [LATENCY-1:0]  pipe_valid;
  tomasulo_pkg::tag_t  pipe_tag  [LATENCY];
  tomasulo_pkg::data_t pipe_data [LATENCY];

  assign disp.full = &rs_busy;
  // whole pipe freezes while the arbiter holds us off
  assign advance   = !res.stall;

  // lowest free slot, scanned downward so index 0 wins
  always_comb
  begin
    free_idx = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--)
      if (!rs_busy[i])
        free_idx = IDX_W'(i);
  end

  // lowest ready entry
  always_comb
  begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--)
    begin
      if (rs_busy[i] && !rs_wait_j[i] && !rs_wait_k[i])
      begin
        sel_found = 1'b1;
        sel_idx   = IDX_W'(i);
      end
    end
  end

  // 8 bit wraparound arithmetic
  always_comb
  begin
    case (rs_func[sel_idx])
      tomasulo_pkg::op_sub: alu_out = rs_vj[sel_idx] - rs_vk[sel_idx];
      tomasulo_pkg::op_mul: alu_out = rs_vj[sel_idx] * rs_vk[sel_idx];
      default:              alu_out = rs_vj[sel_idx] + rs_vk[sel_idx];
    endcase
  end

  always_ff @(posedge clk1)
  begin
    if (reset)
    begin
      rs_busy   <= '0;
      rs_wait_j <= '0;
      rs_wait_k <= '0;
    end
    else
    begin
      // operand capture off the bus
      for (int i = 0; i < RS_DEPTH; i++)
      begin
        if (cdb_valid && rs_busy[i] && rs_wait_j[i] && (rs_qj[i] == cdb_tag))
        begin
          rs_vj[i]     <= cdb_data;
          rs_wait_j[i] <= 1'b0;
        end
        if (cdb_valid && rs_busy[i] && rs_wait_k[i] && (rs_qk[i] == cdb_tag))
        begin
          rs_vk[i]     <= cdb_data;
          rs_wait_k[i] <= 1'b0;
        end
      end
      if (advance && sel_found)
        rs_busy[sel_idx] <= 1'b0;
      // dispatch only lands in a free slot, never the one just issued
      if (disp.valid)
      begin
        rs_busy[free_idx]   <= 1'b1;
        rs_func[free_idx]   <= disp.func;
        rs_tag[free_idx]    <= disp.tag;
        rs_vj[free_idx]     <= disp.vj;
        rs_qj[free_idx]     <= disp.qj;
        rs_wait_j[free_idx] <= disp.qj_valid;
        rs_vk[free_idx]     <= disp.vk;
        rs_qk[free_idx]     <= disp.qk;
        rs_wait_k[free_idx] <= disp.qk_valid;
      end
    end
  end

  always_ff @(posedge clk1)
  begin
    if (reset)
      pipe_valid <= '0;
    else if (advance)
    begin
      pipe_valid[0] <= sel_found;
      for (int i = 1; i < LATENCY; i++)
        pipe_valid[i] <= pipe_valid[i-1];
    end
  end

  // tag rides along with the value
  always_ff @(posedge clk1)
  begin
    if (advance)
    begin
      pipe_tag[0]  <= rs_tag[sel_idx];
      pipe_data[0] <= alu_out;
      for (int i = 1; i < LATENCY; i++)
      begin
        pipe_tag[i]  <= pipe_tag[i-1];
        pipe_data[i] <= pipe_data[i-1];
      end
    end
  end

  assign res.valid = pipe_valid[LATENCY-1];
  assign res.tag   = pipe_tag[LATENCY-1];
  assign res.data  = pipe_data[LATENCY-1];

endmodule

/* issue_unit.sv */
/*
  issue unit
  decodes, renames through the register file and dispatches to the stations
*/
module issue_unit (
  input  logic                clk1,
  input  logic                reset,
  input  logic [15:0]         inst,
  input  logic                inst_valid,
  input  logic                cdb_valid,
  input  tomasulo_pkg::tag_t  cdb_tag,
  input  tomasulo_pkg::data_t cdb_data,
  output logic                issue_ready,
  dispatch_if.source          add_disp,
  dispatch_if.source          mul_disp,
  rob_if.issue                rob_port,
  commit_if.sink              commit_in
);

  // register file with rename state
  tomasulo_pkg::data_t reg_val [tomasulo_pkg::num_regs];
  tomasulo_pkg::tag_t  reg_tag [tomasulo_pkg::num_regs];
  logic [tomasulo_pkg::num_regs-1:0] reg_busy;

  tomasulo_pkg::func_t    func;
  tomasulo_pkg::reg_idx_t rs1;
  tomasulo_pkg::reg_idx_t rs2;
  tomasulo_pkg::reg_idx_t rd;
  logic                   is_add;
  logic                   is_mul;
  logic                   accept;
  logic                   running;
  tomasulo_pkg::data_t    vj;
  tomasulo_pkg::data_t    vk;
  logic                   wait_j;
  logic                   wait_k;

  // field split, same order as the instruction format
  assign func = inst[15:12];
  assign rs1  = inst[11:8];
  assign rs2  = inst[7:4];
  assign rd   = inst[3:0];

  assign is_add = (func == tomasulo_pkg::op_add) || (func == tomasulo_pkg::op_sub);
  assign is_mul = (func == tomasulo_pkg::op_mul);

  // held low for the first cycle out of reset
  assign issue_ready = running && !rob_port.full && !add_disp.full && !mul_disp.full;
  assign accept      = inst_valid && issue_ready;

  // lookups for the pending producers
  assign rob_port.qj_tag   = reg_tag[rs1];
  assign rob_port.qk_tag   = reg_tag[rs2];
  assign rob_port.alloc    = accept && (is_add || is_mul);
  assign rob_port.alloc_rd = rd;

  // operand source order: register, rob value, bus, else wait on tag
  always_comb
  begin
    vj     = reg_val[rs1];
    wait_j = 1'b0;
    if (reg_busy[rs1])
    begin
      if (rob_port.j_ready)
        vj = rob_port.j_data;
      else if (cdb_valid && (cdb_tag == reg_tag[rs1]))
        vj = cdb_data;
      else
        wait_j = 1'b1;
    end
    vk     = reg_val[rs2];
    wait_k = 1'b0;
    if (reg_busy[rs2])
    begin
      if (rob_port.k_ready)
        vk = rob_port.k_data;
      else if (cdb_valid && (cdb_tag == reg_tag[rs2]))
        vk = cdb_data;
      else
        wait_k = 1'b1;
    end
  end

  // both stations see the same payload, only valid differs
  assign add_disp.valid    = accept && is_add;
  assign add_disp.func     = func;
  assign add_disp.tag      = rob_port.tail_tag;
  assign add_disp.vj       = vj;
  assign add_disp.qj       = reg_tag[rs1];
  assign add_disp.qj_valid = wait_j;
  assign add_disp.vk       = vk;
  assign add_disp.qk       = reg_tag[rs2];
  assign add_disp.qk_valid = wait_k;

  assign mul_disp.valid    = accept && is_mul;
  assign mul_disp.func     = func;
  assign mul_disp.tag      = rob_port.tail_tag;
  assign mul_disp.vj       = vj;
  assign mul_disp.qj       = reg_tag[rs1];
  assign mul_disp.qj_valid = wait_j;
  assign mul_disp.vk       = vk;
  assign mul_disp.qk       = reg_tag[rs2];
  assign mul_disp.qk_valid = wait_k;

  always_ff @(posedge clk1)
  begin
    if (reset)
    begin
      running  <= 1'b0;
      reg_busy <= '0;
      for (int i = 0; i < tomasulo_pkg::num_regs; i++)
      begin
        reg_val[i] <= tomasulo_pkg::data_t'(i);
        reg_tag[i] <= '0;
      end
    end
    else
    begin
      running <= 1'b1;
      // retire first so a same-cycle rename of rd keeps its pending mark
      if (commit_in.valid)
      begin
        reg_val[commit_in.rd] <= commit_in.data;
        if (reg_tag[commit_in.rd] == commit_in.tag)
          reg_busy[commit_in.rd] <= 1'b0;
      end
      if (rob_port.alloc)
      begin
        reg_busy[rd] <= 1'b1;
        reg_tag[rd]  <= rob_port.tail_tag;
      end
    end
  end

endmodule

/* tomasulo_ifs.sv */
/*
  interfaces between issue, execute, arbiter and reorder buffer
*/

// issue to one reservation station
interface dispatch_if;
  logic                valid;
  tomasulo_pkg::func_t func;
  tomasulo_pkg::tag_t  tag;
  tomasulo_pkg::data_t vj;
  tomasulo_pkg::tag_t  qj;
  logic                qj_valid;
  tomasulo_pkg::data_t vk;
  tomasulo_pkg::tag_t  qk;
  logic                qk_valid;
  logic                full;

  modport source (output valid, func, tag, vj, qj, qj_valid, vk, qk, qk_valid, input full);
  modport sink (input valid, func, tag, vj, qj, qj_valid, vk, qk, qk_valid, output full);
endinterface

// finished result from a functional unit
interface result_if;
  logic                valid;
  tomasulo_pkg::tag_t  tag;
  tomasulo_pkg::data_t data;
  logic                stall;

  modport unit (output valid, tag, data, input stall);
  modport arbiter (input valid, tag, data, output stall);
endinterface

// allocation and operand lookup
interface rob_if;
  logic                   alloc;
  tomasulo_pkg::reg_idx_t alloc_rd;
  tomasulo_pkg::tag_t     qj_tag;
  tomasulo_pkg::tag_t     qk_tag;
  tomasulo_pkg::tag_t     tail_tag;
  logic                   full;
  logic                   j_ready;
  tomasulo_pkg::data_t    j_data;
  logic                   k_ready;
  tomasulo_pkg::data_t    k_data;

  modport issue (output alloc, alloc_rd, qj_tag, qk_tag,
                 input tail_tag, full, j_ready, j_data, k_ready, k_data);
  modport rob (input alloc, alloc_rd, qj_tag, qk_tag,
               output tail_tag, full, j_ready, j_data, k_ready, k_data);
endinterface

// in-order retirement back to the register file
interface commit_if;
  logic                   valid;
  tomasulo_pkg::tag_t     tag;
  tomasulo_pkg::reg_idx_t rd;
  tomasulo_pkg::data_t    data;

  modport source (output valid, tag, rd, data);
  modport sink (input valid, tag, rd, data);
endinterface

/* tomasulo_pkg.sv */
/*
  tomasulo shared definitions
  opcode codes, field types and reorder buffer sizing for the core
*/
package tomasulo_pkg;

  // instruction word is func, rs1, rs2, rd with 4 bits each
  typedef logic [3:0] func_t;
  typedef logic [3:0] reg_idx_t;

  // register and result value, wraps at 8 bits
  typedef logic [7:0] data_t;

  // reorder buffer index doubles as the rename tag
  typedef logic [2:0] tag_t;

  // supported function codes
  localparam func_t op_add = 4'b0000;
  localparam func_t op_sub = 4'b0001;
  localparam func_t op_mul = 4'b0010;

  // other codes like div, load, store, beq, bneq are dropped at issue

  localparam int rob_depth = 8;

  // 16 architectural registers
  localparam int num_regs = 16;

endpackage
